//--- source/macPkg.sv
`default_nettype none

package macPkg;

    // Operand and product widths of the multiplier
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // Accumulator wraps modulo 2^ACC_W
    localparam int ACC_W = 40;

    // FIFO geometry, depth must stay a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    // One extra bit so a full FIFO can report FIFO_DEPTH
    localparam int COUNT_W = PTR_W + 1;

    // One queued multiplication, 34 bits
    typedef struct packed {
        logic signed [OPERAND_W-1:0] multiplicand;
        logic signed [OPERAND_W-1:0] multiplier;
        // Add product into the running sum
        logic accEn;
        // Restart the sum from zero before this pair
        logic clearFirst;
    } operandPair_t;

    // Plain product or accumulated sum
    typedef logic signed [ACC_W-1:0] result_t;

endpackage

`default_nettype wire

//--- source/regMapPkg.sv
`default_nettype none

package regMapPkg;

    // APB bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Register offsets
    localparam logic [ADDR_W-1:0] REG_OPA = 8'h00;
    localparam logic [ADDR_W-1:0] REG_OPB = 8'h04;
    localparam logic [ADDR_W-1:0] REG_CTRL = 8'h08;
    localparam logic [ADDR_W-1:0] REG_RES_LO = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_RES_HI = 8'h10;
    localparam logic [ADDR_W-1:0] REG_STATUS = 8'h14;

    // CTRL bits
    localparam int CTRL_ACC_EN = 0;
    // Write 1 arms clear for the next queued pair
    localparam int CTRL_CLEAR = 1;

    // STATUS fields, LSB positions of the counts
    localparam int STAT_OP_CNT = 0;
    localparam int STAT_RES_CNT = 4;
    localparam int STAT_CLR_ARMED = 8;

endpackage

`default_nettype wire

//--- source/fifoIf.sv
`default_nettype none

interface fifoIf import macPkg::*; #(
    parameter type payload_t = logic
) ();

    // Write side
    logic push;
    payload_t pushData;
    logic full;

    // Read side, head entry shown before the pop
    logic pop;
    payload_t popData;
    logic empty;

    // Occupancy, visible to both ends
    logic [COUNT_W-1:0] count;

    modport producer (output push, output pushData, input full, input count);

    modport consumer (output pop, input popData, input empty, input count);

    modport storage (
        input push, input pushData, input pop,
        output full, output popData, output empty, output count
    );

endinterface

`default_nettype wire

//--- source/syncFifo.sv
`default_nettype none

module syncFifo import macPkg::*; #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rstN,
    fifoIf.storage fifo
);

    // Entry storage
    payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [COUNT_W-1:0] level;
    logic doPush;
    logic doPop;

    // Push ignored when full, pop ignored when empty
    assign doPush = fifo.push && !fifo.full;
    assign doPop = fifo.pop && !fifo.empty;

    assign fifo.full = (level == COUNT_W'(FIFO_DEPTH));
    assign fifo.empty = (level == '0);
    assign fifo.count = level;
    // Head entry always on the read port
    assign fifo.popData = mem[rdPtr];

    // Storage write
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= fifo.pushData;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Push together with pop leaves the level alone
            if (doPush && !doPop) begin
                level <= level + 1'b1;
            end else if (doPop && !doPush) begin
                level <= level - 1'b1;
            end
        end
    end

    // Level bounded by depth across any push/pop history
    levelBounded: assert property (
        @(posedge clk) disable iff (!rstN) level <= COUNT_W'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

//--- source/arrayMultiplier.sv
`default_nettype none

module arrayMultiplier import macPkg::*; (
    input logic signed [OPERAND_W-1:0] multiplicand,
    input logic signed [OPERAND_W-1:0] multiplier,
    output logic signed [PRODUCT_W-1:0] product
);

    logic negMcand;
    logic negMplier;
    logic negProduct;
    logic [OPERAND_W-1:0] magMcand;
    logic [OPERAND_W-1:0] magMplier;
    // One AND row per multiplier bit
    logic [OPERAND_W-1:0] ppRow [OPERAND_W];
    // Running sum after each row
    logic [PRODUCT_W-1:0] rowSum [OPERAND_W];

    assign negMcand = multiplicand[OPERAND_W-1];
    assign negMplier = multiplier[OPERAND_W-1];
    // Result negative when exactly one operand is
    assign negProduct = negMcand ^ negMplier;

    // Magnitudes, -32768 maps to 0x8000 which is still correct unsigned
    always_comb begin
        magMcand = multiplicand;
        magMplier = multiplier;
        if (negMcand) begin
            magMcand = ~multiplicand + 1'b1;
        end
        if (negMplier) begin
            magMplier = ~multiplier + 1'b1;
        end
    end

    // Partial product array
    for (genvar i = 0; i < OPERAND_W; i++) begin : genRows
        assign ppRow[i] = magMcand & {OPERAND_W{magMplier[i]}};
    end

    // Ripple chain of row additions
    assign rowSum[0] = {{(PRODUCT_W-OPERAND_W){1'b0}}, ppRow[0]};
    for (genvar i = 1; i < OPERAND_W; i++) begin : genSums
        assign rowSum[i] = rowSum[i-1] + ({{(PRODUCT_W-OPERAND_W){1'b0}}, ppRow[i]} << i);
    end

    // Sign fix-up on the unsigned magnitude product
    always_comb begin
        product = rowSum[OPERAND_W-1];
        if (negProduct) begin
            product = ~rowSum[OPERAND_W-1] + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/productAccumulator.sv
`default_nettype none

module productAccumulator import macPkg::*; (
    input logic clk,
    input logic rstN,
    fifoIf.consumer opIf,
    fifoIf.producer resIf
);

    logic signed [PRODUCT_W-1:0] product;

    // Stage between pop and result push
    logic stValid;
    logic signed [PRODUCT_W-1:0] stProduct;
    logic stAccEn;
    logic stClearFirst;

    logic advance;
    logic load;
    result_t accReg;
    result_t extProduct;
    result_t accBase;
    result_t newAcc;

    // Multiply straight off the FIFO head
    arrayMultiplier mult_i (
        .multiplicand(opIf.popData.multiplicand),
        .multiplier(opIf.popData.multiplier),
        .product(product)
    );

    // Staged entry leaves once the result FIFO has room
    assign advance = stValid && !resIf.full;
    // Refill when the stage is free or emptying this cycle
    assign load = !opIf.empty && (!stValid || advance);
    assign opIf.pop = load;

    always_comb begin
        extProduct = {{(ACC_W-PRODUCT_W){stProduct[PRODUCT_W-1]}}, stProduct};
        accBase = stClearFirst ? '0 : accReg;
        // Plain mode passes the product through
        newAcc = stAccEn ? (accBase + extProduct) : extProduct;
    end

    assign resIf.push = advance;
    assign resIf.pushData = newAcc;

    // Stage valid bit
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stValid <= 1'b0;
        end else if (load) begin
            stValid <= 1'b1;
        end else if (advance) begin
            stValid <= 1'b0;
        end
    end

    // Stage payload captured at the pop edge
    always_ff @(posedge clk) begin
        if (load) begin
            stProduct <= product;
            stAccEn <= opIf.popData.accEn;
            stClearFirst <= opIf.popData.clearFirst;
        end
    end

    // Running sum, wraps modulo 2^ACC_W
    always_ff @(posedge clk) begin
        if (!rstN) begin
            accReg <= '0;
        end else if (advance && stAccEn) begin
            accReg <= newAcc;
        end
    end

    resNoOverflow: assert property (
        @(posedge clk) disable iff (!rstN) resIf.push |-> !resIf.full
    );

endmodule

`default_nettype wire

//--- source/apbRegCtrl.sv
`default_nettype none

module apbRegCtrl import macPkg::*, regMapPkg::*; (
    input logic clk,
    input logic rstN,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [ADDR_W-1:0] paddr,
    input logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,
    fifoIf.producer opIf,
    fifoIf.consumer resIf
);

    logic access;
    logic wrAccess;
    logic rdAccess;

    // Address decode
    logic selOpa;
    logic selOpb;
    logic selCtrl;
    logic selResLo;
    logic selResHi;
    logic selStatus;
    logic mapped;

    logic signed [OPERAND_W-1:0] opAReg;
    logic accEnReg;
    // Sticky until the next pair is queued
    logic clearArmed;

    operandPair_t newPair;
    logic [DATA_W-1:0] statusWord;
    logic [DATA_W-1:0] rdData;

    // No wait states
    assign pready = 1'b1;

    // Transfer completes in the access phase
    assign access = psel && penable;
    assign wrAccess = access && pwrite;
    assign rdAccess = access && !pwrite;

    assign selOpa = (paddr == REG_OPA);
    assign selOpb = (paddr == REG_OPB);
    assign selCtrl = (paddr == REG_CTRL);
    assign selResLo = (paddr == REG_RES_LO);
    assign selResHi = (paddr == REG_RES_HI);
    assign selStatus = (paddr == REG_STATUS);
    assign mapped = selOpa || selOpb || selCtrl || selResLo || selResHi || selStatus;

    // Error on unmapped, OPB into a full FIFO, RES_HI from an empty FIFO
    assign pslverr = access && (!mapped
                                || (pwrite && selOpb && opIf.full)
                                || (!pwrite && selResHi && resIf.empty));

    // Pair takes the mode bits live at the OPB write
    always_comb begin
        newPair.multiplicand = opAReg;
        newPair.multiplier = pwdata[OPERAND_W-1:0];
        newPair.accEn = accEnReg;
        newPair.clearFirst = clearArmed;
    end

    assign opIf.push = wrAccess && selOpb && !opIf.full;
    assign opIf.pushData = newPair;

    // Reading the high word retires the head result
    assign resIf.pop = rdAccess && selResHi && !resIf.empty;

    always_comb begin
        statusWord = '0;
        statusWord[STAT_OP_CNT +: COUNT_W] = opIf.count;
        statusWord[STAT_RES_CNT +: COUNT_W] = resIf.count;
        statusWord[STAT_CLR_ARMED] = clearArmed;
    end

    // Read mux, zero outside a read access
    always_comb begin
        rdData = '0;
        if (rdAccess) begin
            case (paddr)
                REG_CTRL: begin
                    rdData[CTRL_ACC_EN] = accEnReg;
                    rdData[CTRL_CLEAR] = clearArmed;
                end
                REG_RES_LO: begin
                    // Empty FIFO reads as zero
                    if (!resIf.empty) begin
                        rdData = resIf.popData[DATA_W-1:0];
                    end
                end
                REG_RES_HI: begin
                    if (!resIf.empty) begin
                        rdData = {{(2*DATA_W-ACC_W){resIf.popData[ACC_W-1]}},
                                  resIf.popData[ACC_W-1:DATA_W]};
                    end
                end
                REG_STATUS: rdData = statusWord;
                default: rdData = '0;
            endcase
        end
    end

    assign prdata = rdData;

    // Multiplicand holding register
    always_ff @(posedge clk) begin
        if (wrAccess && selOpa) begin
            opAReg <= pwdata[OPERAND_W-1:0];
        end
    end

    // Mode bit and clear flag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            accEnReg <= 1'b0;
            clearArmed <= 1'b0;
        end else begin
            if (wrAccess && selCtrl) begin
                accEnReg <= pwdata[CTRL_ACC_EN];
                if (pwdata[CTRL_CLEAR]) begin
                    clearArmed <= 1'b1;
                end
            end
            // Consumed by the pair that carries it
            if (opIf.push) begin
                clearArmed <= 1'b0;
            end
        end
    end

    apbEnableNeedsSel: assert property (
        @(posedge clk) disable iff (!rstN) penable |-> psel
    );

    opNoOverflow: assert property (
        @(posedge clk) disable iff (!rstN) opIf.push |-> !opIf.full
    );

endmodule

`default_nettype wire

//--- source/mulAccTop.sv
`default_nettype none

module mulAccTop import macPkg::*, regMapPkg::*; (
    input logic clk,
    input logic rstN,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [ADDR_W-1:0] paddr,
    input logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr
);

    // Operand pairs from APB to the datapath
    fifoIf #(.payload_t(operandPair_t)) opIf ();
    // Results back to APB
    fifoIf #(.payload_t(result_t)) resIf ();

    apbRegCtrl regCtrl_i (
        .clk(clk),
        .rstN(rstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .opIf(opIf),
        .resIf(resIf)
    );

    syncFifo #(.payload_t(operandPair_t)) opFifo_i (
        .clk(clk),
        .rstN(rstN),
        .fifo(opIf)
    );

    productAccumulator accum_i (
        .clk(clk),
        .rstN(rstN),
        .opIf(opIf),
        .resIf(resIf)
    );

    syncFifo #(.payload_t(result_t)) resFifo_i (
        .clk(clk),
        .rstN(rstN),
        .fifo(resIf)
    );

endmodule

`default_nettype wire

//--- tb/mulAccTb.sv
`default_nettype none

module mulAccTb import macPkg::*, regMapPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Stimulus sizes, also used for the watchdog budget
    localparam int CORNER_N = 5;
    localparam int RAND_PAIRS = 200;
    localparam int ACC_PAIRS = 30;
    // Four in each FIFO plus one in the stage
    localparam int BP_PAIRS = 2 * FIFO_DEPTH + 1;
    // Enough pairs to leave some waiting behind a full result FIFO
    localparam int CAPTURE_PAIRS = 2 * FIFO_DEPTH + 1;
    localparam int NUM_PAIRS = CORNER_N * CORNER_N + RAND_PAIRS + ACC_PAIRS
                               + BP_PAIRS + 1 + CAPTURE_PAIRS;
    localparam int WATCHDOG_CYCLES = NUM_PAIRS * 20 + 500;

    logic clk;
    logic rstN;
    logic psel;
    logic penable;
    logic pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;

    int seed = 27486;
    logic signed [OPERAND_W-1:0] corners [CORNER_N] = '{0, 1, -1, -32768, 32767};

    // Software view of CTRL and the running sum
    logic modelAccEn;
    logic modelClearArmed;
    result_t modelAcc;
    // Expected results in queue order, and values read back over APB
    result_t expQ [$];
    result_t gotQ [$];

    mulAccTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else
            stopRun($sformatf("error at %0d ns: %s expected %0h got %0h",
                              $time, name, exp, got));
    endtask

    // Exact signed product, sign-extended to the accumulator width
    function automatic result_t refProduct(input logic signed [OPERAND_W-1:0] a,
                                           input logic signed [OPERAND_W-1:0] b);
        longint p;
        p = longint'(a) * longint'(b);
        return p[ACC_W-1:0];
    endfunction

    // Called 1 ns after a rising edge, returns at the same offset
    task automatic apbWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1 penable = 1'b1;
        // Mid access phase, responses are settled
        #4 err = pslverr;
        checkEqual("pready", pready, 1);
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        // Sample before the edge that may pop the result FIFO
        #4 data = prdata;
        err = pslverr;
        checkEqual("pready", pready, 1);
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic readStatus(output logic [DATA_W-1:0] stat);
        logic err;
        apbRead(REG_STATUS, stat, err);
        checkEqual("pslverr", err, 0);
    endtask

    task automatic writeCtrl(input logic accEn, input logic clear);
        logic [DATA_W-1:0] data;
        logic err;
        data = '0;
        data[CTRL_ACC_EN] = accEn;
        data[CTRL_CLEAR] = clear;
        apbWrite(REG_CTRL, data, err);
        checkEqual("pslverr", err, 0);
        modelAccEn = accEn;
        if (clear) begin
            modelClearArmed = 1'b1;
        end
    endtask

    // Writes both operands, models the result when the pair is accepted
    task automatic queuePair(input logic signed [OPERAND_W-1:0] a,
                             input logic signed [OPERAND_W-1:0] b, input logic expectErr);
        logic err;
        result_t prod;
        result_t base;
        apbWrite(REG_OPA, DATA_W'(a), err);
        checkEqual("pslverr", err, 0);
        apbWrite(REG_OPB, DATA_W'(b), err);
        checkEqual("pslverr", err, expectErr);
        if (!expectErr) begin
            prod = refProduct(a, b);
            if (modelAccEn) begin
                base = modelClearArmed ? '0 : modelAcc;
                modelAcc = base + prod;
                expQ.push_back(modelAcc);
            end else begin
                expQ.push_back(prod);
            end
            modelClearArmed = 1'b0;
        end
    endtask

    // Waits for a result in STATUS, then reads both words
    task automatic readResult();
        logic [DATA_W-1:0] stat;
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        logic err;
        stat = '0;
        while (stat[STAT_RES_CNT +: COUNT_W] == 0) begin
            readStatus(stat);
        end
        apbRead(REG_RES_LO, lo, err);
        checkEqual("pslverr", err, 0);
        apbRead(REG_RES_HI, hi, err);
        checkEqual("pslverr", err, 0);
        checkEqual("prdata RES_HI sign bits", hi[DATA_W-1:ACC_W-DATA_W],
                   {(2*DATA_W-ACC_W){hi[ACC_W-DATA_W-1]}});
        gotQ.push_back({hi[ACC_W-DATA_W-1:0], lo});
    endtask

    task automatic randOperands(output logic signed [OPERAND_W-1:0] a,
                                output logic signed [OPERAND_W-1:0] b);
        a = OPERAND_W'($random(seed));
        b = OPERAND_W'($random(seed));
    endtask

    // Compare process, matches read-back values against the model in order
    initial begin
        result_t got;
        result_t exp;
        forever begin
            @(posedge clk);
            while (gotQ.size() != 0) begin
                assert (expQ.size() != 0) else
                    stopRun("a result was read back with no expected value queued");
                got = gotQ.pop_front();
                exp = expQ.pop_front();
                checkEqual("result", got, exp);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stopRun("timeout, the DUT did not finish the test sequence in time");
    end

    initial begin
        logic signed [OPERAND_W-1:0] a;
        logic signed [OPERAND_W-1:0] b;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] stat;
        logic err;
        rstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        modelAccEn = 1'b0;
        modelClearArmed = 1'b0;
        modelAcc = '0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;

        // Plain mode, corners crossed, then random pairs
        writeCtrl(1'b0, 1'b0);
        for (int i = 0; i < CORNER_N; i++) begin
            for (int j = 0; j < CORNER_N; j++) begin
                queuePair(corners[i], corners[j], 1'b0);
                readResult();
            end
        end
        repeat (RAND_PAIRS) begin
            randOperands(a, b);
            queuePair(a, b, 1'b0);
            readResult();
        end

        // Accumulate mode with a restart halfway
        writeCtrl(1'b1, 1'b1);
        for (int i = 0; i < ACC_PAIRS; i++) begin
            if (i == ACC_PAIRS / 2) begin
                writeCtrl(1'b1, 1'b1);
                readStatus(stat);
                checkEqual("STATUS clear armed", stat[STAT_CLR_ARMED], 1);
                readStatus(stat);
                checkEqual("STATUS clear armed", stat[STAT_CLR_ARMED], 1);
            end
            randOperands(a, b);
            queuePair(a, b, 1'b0);
            if (i == ACC_PAIRS / 2) begin
                readStatus(stat);
                checkEqual("STATUS clear armed", stat[STAT_CLR_ARMED], 0);
            end
            readResult();
        end

        // Back-pressure, fill stage and both FIFOs without reading
        for (int i = 0; i < BP_PAIRS; i++) begin
            randOperands(a, b);
            queuePair(a, b, 1'b0);
        end
        stat = '0;
        while (stat[STAT_OP_CNT +: COUNT_W] != FIFO_DEPTH
               || stat[STAT_RES_CNT +: COUNT_W] != FIFO_DEPTH) begin
            readStatus(stat);
        end
        // This one must be refused and dropped
        randOperands(a, b);
        queuePair(a, b, 1'b1);
        readStatus(stat);
        checkEqual("STATUS op count", stat[STAT_OP_CNT +: COUNT_W], FIFO_DEPTH);
        checkEqual("STATUS res count", stat[STAT_RES_CNT +: COUNT_W], FIFO_DEPTH);
        repeat (BP_PAIRS) begin
            readResult();
        end

        // Error responses, result FIFO is empty here
        apbRead(8'h18, data, err);
        checkEqual("pslverr", err, 1);
        apbWrite(8'h1C, 32'h1234, err);
        checkEqual("pslverr", err, 1);
        apbRead(REG_RES_HI, data, err);
        checkEqual("pslverr", err, 1);
        apbRead(REG_RES_LO, data, err);
        checkEqual("pslverr", err, 0);
        checkEqual("prdata RES_LO", data, 0);

        // Mode taken at queue time, CTRL changes while pairs wait in stage and FIFO
        writeCtrl(1'b0, 1'b0);
        for (int i = 0; i < CAPTURE_PAIRS; i++) begin
            if (i == FIFO_DEPTH + 2) begin
                writeCtrl(1'b1, 1'b1);
            end
            randOperands(a, b);
            queuePair(a, b, 1'b0);
        end
        writeCtrl(1'b0, 1'b0);
        repeat (CAPTURE_PAIRS) begin
            readResult();
        end

        // Let the compare process catch up
        repeat (2) @(posedge clk);
        if (gotQ.size() == 0 && expQ.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stopRun("expected and read-back results do not match in number");
        end
    end

endmodule

`default_nettype wire

//--- mulAcc.f
source/macPkg.sv
source/regMapPkg.sv
source/fifoIf.sv
source/syncFifo.sv
source/arrayMultiplier.sv
source/productAccumulator.sv
source/apbRegCtrl.sv
source/mulAccTop.sv
tb/mulAccTb.sv
